// File: project.f
+incdir+tb
source/mont_word_pkg.sv
source/modexp_ctrl_pkg.sv
source/monpro_if.sv
source/mont_product.sv
source/operand_store.sv
source/modexp_ctrl.sv
source/modexp.sv
tb/modexp_tb.sv

// File: Bender.yml
package:
  name: modexp

sources:
  # design, packages first
  - files:
      - source/mont_word_pkg.sv
      - source/modexp_ctrl_pkg.sv
      - source/monpro_if.sv
      - source/mont_product.sv
      - source/operand_store.sv
      - source/modexp_ctrl.sv
      - source/modexp.sv
  # testbench, top module modexp_tb
  - target: test
    include_dirs:
      - tb
    files:
      - tb/modexp_tb.sv

// File: tb/modexp_ref.svh
/* reference arithmetic and random source for the exponentiator testbench
   included inside the testbench module, which declares OP_W before the include */
`ifndef MODEXP_REF_SVH
`define MODEXP_REF_SVH

// 32-bit linear congruential generator
function automatic logic [31:0] lcg_step(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// a * b mod n over a double width product
function automatic logic [OP_W-1:0] mod_mul(input logic [OP_W-1:0] a,
		input logic [OP_W-1:0] b, input logic [OP_W-1:0] n);
	logic [2*OP_W-1:0] prod;
	logic [2*OP_W-1:0] rem;
	prod = {{OP_W{1'b0}}, a} * {{OP_W{1'b0}}, b};
	rem = prod % {{OP_W{1'b0}}, n};
	return rem[OP_W-1:0];
endfunction

// R mod n with R = 2^OP_W
function automatic logic [OP_W-1:0] mont_r(input logic [OP_W-1:0] n);
	logic [2*OP_W-1:0] big;
	logic [2*OP_W-1:0] rem;
	big = '0;
	big[OP_W] = 1'b1;
	rem = big % {{OP_W{1'b0}}, n};
	return rem[OP_W-1:0];
endfunction

// -n0^-1 mod 2^64 by Newton iteration
function automatic logic [63:0] neg_inv64(input logic [63:0] n0);
	logic [63:0] x;
	int k;
	x = n0; // odd n0 is its own inverse mod 8
	for (k = 0; k < 5; k++) begin
		x = x * (64'd2 - n0 * x); // doubles the number of correct low bits
	end
	return -x;
endfunction

// left-to-right square-and-multiply, m below n
function automatic logic [OP_W-1:0] mod_exp(input logic [OP_W-1:0] m,
		input logic [OP_W-1:0] e, input logic [OP_W-1:0] n);
	logic [OP_W-1:0] acc;
	int b;
	acc = 1;
	for (b = OP_W - 1; b >= 0; b--) begin
		acc = mod_mul(acc, acc, n);
		if (e[b]) begin
			acc = mod_mul(acc, m, n);
		end
	end
	return acc;
endfunction

`endif

// File: tb/modexp_tb.sv
/* self-checking testbench for the modular exponentiator with two-word operands
   loads keys and messages, then compares each result stream with reference arithmetic */
`timescale 1ns/1ps

module modexp_tb;
	import mont_word_pkg::*;

	localparam int WORD_COUNT = 2;
	localparam int OP_W = WORD_COUNT * WORD_WIDTH;
	localparam int COMPUTE_TIMEOUT = 20000; // enough cycles for a full length exponent
	localparam int STREAM_TIMEOUT = 16;
	localparam int RANDOM_KEYS = 3;

	logic clk;
	logic reset;
	logic start_input;
	logic start_compute;
	logic load_next;
	logic get_result;
	word_t m_word;
	word_t e_word;
	word_t r_word;
	word_t t_word;
	word_t n_word;
	word_t nprime0_word;
	logic done;
	logic res_valid;
	word_t res_out;

	logic [31:0] lcg_state;
	logic [OP_W-1:0] key_e;
	logic [OP_W-1:0] key_n;
	logic [OP_W-1:0] msg;

	`include "modexp_ref.svh"

	modexp #(.WORD_COUNT(WORD_COUNT)) uut (
		.clk(clk),
		.reset(reset),
		.start_input(start_input),
		.start_compute(start_compute),
		.load_next(load_next),
		.get_result(get_result),
		.m_word(m_word),
		.e_word(e_word),
		.r_word(r_word),
		.t_word(t_word),
		.n_word(n_word),
		.nprime0_word(nprime0_word),
		.done(done),
		.res_valid(res_valid),
		.res_out(res_out)
	);

	always #10 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1, "stopped at the first failed check");
	endtask

	task automatic check_value(input string name, input word_t got, input word_t expected);
		assert (got === expected)
		else abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, expected));
	endtask

	// inputs change and outputs are read 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic draw_operand(output logic [OP_W-1:0] x);
		int w;
		for (w = 0; w < WORD_COUNT; w++) begin
			lcg_state = lcg_step(lcg_state);
			x[w*WORD_WIDTH+32 +: 32] = lcg_state;
			lcg_state = lcg_step(lcg_state);
			x[w*WORD_WIDTH +: 32] = lcg_state;
		end
	endtask

	task automatic draw_modulus(output logic [OP_W-1:0] n);
		draw_operand(n);
		n[OP_W-1 -: 2] = 2'b00; // below R/4
		n[OP_W-3] = 1'b1;       // near full width
		n[0] = 1'b1;
	endtask

	task automatic draw_message(input logic [OP_W-1:0] n, output logic [OP_W-1:0] m);
		draw_operand(m);
		m = m % n;
	endtask

	task automatic load_key_words(input logic [OP_W-1:0] e, input logic [OP_W-1:0] n);
		logic [OP_W-1:0] r;
		logic [OP_W-1:0] t;
		int w;
		r = mont_r(n);
		t = mod_mul(r, r, n); // R^2 mod n
		start_input = 1'b1;
		next_cycle();
		start_input = 1'b0;
		nprime0_word = neg_inv64(n[WORD_WIDTH-1:0]);
		for (w = 0; w < WORD_COUNT; w++) begin
			e_word = e[w*WORD_WIDTH +: WORD_WIDTH];
			r_word = r[w*WORD_WIDTH +: WORD_WIDTH];
			t_word = t[w*WORD_WIDTH +: WORD_WIDTH];
			n_word = n[w*WORD_WIDTH +: WORD_WIDTH];
			next_cycle();
		end
		e_word = '0;
		r_word = '0;
		t_word = '0;
		n_word = '0;
		nprime0_word = '0;
	endtask

	task automatic load_message(input logic [OP_W-1:0] m);
		int w;
		for (w = 0; w < WORD_COUNT; w++) begin
			m_word = m[w*WORD_WIDTH +: WORD_WIDTH];
			next_cycle();
		end
		m_word = '0;
	endtask

	task automatic read_result(input logic [OP_W-1:0] expected);
		int cycles;
		int w;
		cycles = 0;
		while (!res_valid) begin
			check_value("res_out", res_out, '0); // zero while not valid
			next_cycle();
			cycles++;
			assert (cycles <= STREAM_TIMEOUT)
			else abort_run("timed out waiting for res_valid after get_result");
		end
		for (w = 0; w < WORD_COUNT; w++) begin
			assert (res_valid)
			else abort_run("res_valid dropped before the last result word");
			check_value($sformatf("res_out word %0d", w), res_out,
				expected[w*WORD_WIDTH +: WORD_WIDTH]);
			next_cycle();
		end
		repeat (4) begin
			assert (!res_valid)
			else abort_run("res_valid stayed high past the last result word");
			check_value("res_out", res_out, '0);
			assert (!done)
			else abort_run("done rose again after the result stream");
			next_cycle();
		end
	endtask

	task automatic compute_and_check(input logic [OP_W-1:0] expected);
		int cycles;
		start_compute = 1'b1;
		next_cycle();
		start_compute = 1'b0;
		assert (!done)
		else abort_run("done was high right after start_compute");
		cycles = 0;
		while (!done) begin
			next_cycle();
			cycles++;
			assert (cycles <= COMPUTE_TIMEOUT)
			else abort_run("timed out waiting for done after start_compute");
		end
		get_result = 1'b1;
		next_cycle();
		get_result = 1'b0;
		read_result(expected);
	endtask

	task automatic exponentiate(input logic [OP_W-1:0] e, input logic [OP_W-1:0] n,
			input logic [OP_W-1:0] m);
		load_key_words(e, n);
		load_message(m); // follows the key with no gap
		compute_and_check(mod_exp(m, e, n));
	endtask

	initial begin
		int trial;
		clk = 1'b0;
		reset = 1'b1;
		start_input = 1'b0;
		start_compute = 1'b0;
		load_next = 1'b0;
		get_result = 1'b0;
		m_word = '0;
		e_word = '0;
		r_word = '0;
		t_word = '0;
		n_word = '0;
		nprime0_word = '0;
		lcg_state = 32'h6b84;

		apply_reset();
		assert (!done)
		else abort_run("done is high after reset");
		assert (!res_valid)
		else abort_run("res_valid is high after reset");
		check_value("res_out", res_out, '0);

		// e = 1 gives back m mod n
		draw_modulus(key_n);
		draw_message(key_n, msg);
		key_e = 1;
		exponentiate(key_e, key_n, msg);

		for (trial = 0; trial < RANDOM_KEYS; trial++) begin
			apply_reset(); // a new key needs the idle phase
			draw_modulus(key_n);
			draw_operand(key_e);
			draw_message(key_n, msg);
			exponentiate(key_e, key_n, msg);
		end

		// zero top word of e makes the scan cross into word 0
		apply_reset();
		draw_modulus(key_n);
		draw_operand(key_e);
		key_e[OP_W-1:WORD_WIDTH] = '0;
		draw_message(key_n, msg);
		exponentiate(key_e, key_n, msg);

		// new message under the same key
		draw_message(key_n, msg);
		load_next = 1'b1;
		next_cycle();
		load_next = 1'b0;
		load_message(msg);
		compute_and_check(mod_exp(msg, key_e, key_n));

		$display("** PASS **");
		$finish;
	end

endmodule

// File: source/modexp.sv
/* word-serial Montgomery modular exponentiator c = m^e mod n with plain ports
   key words load first, then messages, each followed by start_compute and get_result */
`timescale 1ns/1ps

module modexp #(
	parameter int WORD_COUNT = 64
) (
	input  logic clk,
	input  logic reset,
	input  logic start_input,
	input  logic start_compute,
	input  logic load_next,
	input  logic get_result,
	input  mont_word_pkg::word_t m_word,
	input  mont_word_pkg::word_t e_word,
	input  mont_word_pkg::word_t r_word,
	input  mont_word_pkg::word_t t_word,
	input  mont_word_pkg::word_t n_word,
	input  mont_word_pkg::word_t nprime0_word,
	output logic done,
	output logic res_valid,
	output mont_word_pkg::word_t res_out
);
	import mont_word_pkg::*;
	import modexp_ctrl_pkg::*;

	localparam int BIT_W = $clog2(WORD_COUNT * WORD_WIDTH);

	logic mp_start;
	logic mp_done;
	logic load_key;
	logic load_msg;
	logic stream_out;
	logic e_bit;
	logic last_word;
	operand_sel_t operand_sel;
	logic [BIT_W-1:0] bit_index;

	monpro_if #(.WORD_COUNT(WORD_COUNT)) mp_bus ();

	modexp_ctrl #(.WORD_COUNT(WORD_COUNT)) u_ctrl (
		.clk(clk),
		.reset(reset),
		.start_input(start_input),
		.start_compute(start_compute),
		.load_next(load_next),
		.get_result(get_result),
		.e_bit(e_bit),
		.last_word(last_word),
		.mp_done(mp_done),
		.mp_start(mp_start),
		.operand_sel(operand_sel),
		.load_key(load_key),
		.load_msg(load_msg),
		.stream_out(stream_out),
		.bit_index(bit_index),
		.done(done)
	);

	operand_store #(.WORD_COUNT(WORD_COUNT)) u_store (
		.clk(clk),
		.reset(reset),
		.load_key(load_key),
		.load_msg(load_msg),
		.stream_out(stream_out),
		.operand_sel(operand_sel),
		.bit_index(bit_index),
		.m_word(m_word),
		.e_word(e_word),
		.r_word(r_word),
		.t_word(t_word),
		.n_word(n_word),
		.nprime0_word(nprime0_word),
		.e_bit(e_bit),
		.last_word(last_word),
		.res_valid(res_valid),
		.res_out(res_out),
		.mp(mp_bus.store)
	);

	mont_product #(.WORD_COUNT(WORD_COUNT)) u_product (
		.clk(clk),
		.reset(reset),
		.start(mp_start),
		.done(mp_done),
		.mp(mp_bus.engine)
	);

endmodule

// File: source/modexp_ctrl.sv
/* exponent sequencer for left-to-right square-and-multiply over Montgomery products
   walks the load phases, the conversions, the bit scan of e and the result stream */
`timescale 1ns/1ps

module modexp_ctrl #(
	parameter int WORD_COUNT = 64,
	localparam int BIT_W = $clog2(WORD_COUNT * mont_word_pkg::WORD_WIDTH)
) (
	input  logic clk,
	input  logic reset,
	input  logic start_input,
	input  logic start_compute,
	input  logic load_next,
	input  logic get_result,
	input  logic e_bit,
	input  logic last_word,
	input  logic mp_done,
	output logic mp_start,
	output modexp_ctrl_pkg::operand_sel_t operand_sel,
	output logic load_key,
	output logic load_msg,
	output logic stream_out,
	output logic [BIT_W-1:0] bit_index,
	output logic done
);
	import mont_word_pkg::*;
	import modexp_ctrl_pkg::*;

	localparam logic [BIT_W-1:0] TOP_BIT = BIT_W'(WORD_COUNT * WORD_WIDTH - 1);

	exp_state_t state;

	assign load_key = (state == LOAD_KEY);
	assign load_msg = (state == LOAD_MSG);
	assign stream_out = (state == OUTPUT);
	assign done = (state == COMPLETE);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			operand_sel <= SEL_M_T;
			bit_index <= '0;
			mp_start <= 1'b0;
		end else begin
			mp_start <= 1'b0;
			case (state)
				IDLE: if (start_input) state <= LOAD_KEY;
				LOAD_KEY: if (last_word) state <= LOAD_MSG;
				LOAD_MSG: if (last_word) state <= WAIT_COMPUTE;
				WAIT_COMPUTE: begin
					if (start_compute) begin
						state <= TO_MONT;
						operand_sel <= SEL_M_T;
						mp_start <= 1'b1;
					end
				end
				TO_MONT: begin
					if (mp_done) begin
						state <= FIND_TOP_BIT;
						bit_index <= TOP_BIT;
					end
				end
				FIND_TOP_BIT: begin // one bit per cycle
					if (e_bit) begin
						state <= SQUARE;
						operand_sel <= SEL_C_C;
						mp_start <= 1'b1;
					end else if (bit_index == '0) begin
						state <= FROM_MONT; // e = 0 leaves c = 1
						operand_sel <= SEL_ONE_C;
						mp_start <= 1'b1;
					end else begin
						bit_index <= bit_index - 1'b1;
					end
				end
				SQUARE: begin
					if (mp_done) begin
						mp_start <= 1'b1;
						if (e_bit) begin
							state <= MULTIPLY;
							operand_sel <= SEL_C_M;
						end else if (bit_index == '0) begin
							state <= FROM_MONT;
							operand_sel <= SEL_ONE_C;
						end else begin
							bit_index <= bit_index - 1'b1; // square again for the next bit
							operand_sel <= SEL_C_C;
						end
					end
				end
				MULTIPLY: begin
					if (mp_done) begin
						mp_start <= 1'b1;
						if (bit_index == '0) begin
							state <= FROM_MONT;
							operand_sel <= SEL_ONE_C;
						end else begin
							bit_index <= bit_index - 1'b1;
							state <= SQUARE;
							operand_sel <= SEL_C_C;
						end
					end
				end
				FROM_MONT: if (mp_done) state <= COMPLETE;
				COMPLETE: if (get_result) state <= OUTPUT;
				OUTPUT: if (last_word) state <= TERMINAL;
				TERMINAL: if (load_next) state <= LOAD_MSG; // same key, new message
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// File: source/operand_store.sv
/* word memories for the key, the message and the Montgomery operands m_bar and c_bar
   loads and result streaming walk one shared word counter, last_word marks its final word */
`timescale 1ns/1ps

module operand_store #(
	parameter int WORD_COUNT = 64,
	localparam int BIT_W = $clog2(WORD_COUNT * mont_word_pkg::WORD_WIDTH)
) (
	input  logic clk,
	input  logic reset,
	input  logic load_key,
	input  logic load_msg,
	input  logic stream_out,
	input  modexp_ctrl_pkg::operand_sel_t operand_sel,
	input  logic [BIT_W-1:0] bit_index,
	input  mont_word_pkg::word_t m_word,
	input  mont_word_pkg::word_t e_word,
	input  mont_word_pkg::word_t r_word,
	input  mont_word_pkg::word_t t_word,
	input  mont_word_pkg::word_t n_word,
	input  mont_word_pkg::word_t nprime0_word,
	output logic e_bit,
	output logic last_word,
	output logic res_valid,
	output mont_word_pkg::word_t res_out,
	monpro_if.store mp
);
	import mont_word_pkg::*;
	import modexp_ctrl_pkg::*;

	localparam int IDX_W = (WORD_COUNT > 1) ? $clog2(WORD_COUNT) : 1;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(WORD_COUNT - 1);

	word_t e_mem [WORD_COUNT];
	word_t r_mem [WORD_COUNT]; // R mod n
	word_t t_mem [WORD_COUNT]; // R^2 mod n
	word_t n_mem [WORD_COUNT];
	word_t m_mem [WORD_COUNT];
	word_t m_bar [WORD_COUNT];
	word_t c_bar [WORD_COUNT];
	word_t nprime0;
	logic [IDX_W-1:0] cnt;
	logic active;

	assign active = load_key || load_msg || stream_out;
	assign last_word = active && (cnt == LAST_IDX);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cnt <= '0;
		end else if (last_word) begin
			cnt <= '0;
		end else if (active) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load_key) begin
			e_mem[cnt] <= e_word;
			r_mem[cnt] <= r_word;
			t_mem[cnt] <= t_word;
			n_mem[cnt] <= n_word;
			if (cnt == '0) begin
				nprime0 <= nprime0_word;
			end
		end
		if (load_msg) begin
			m_mem[cnt] <= m_word;
		end
		if (mp.res_we) begin
			if (operand_sel == SEL_M_T) begin
				m_bar[mp.res_index] <= mp.res_word;
				c_bar[mp.res_index] <= r_mem[mp.res_index]; // c starts as montgomery 1
			end else begin
				c_bar[mp.res_index] <= mp.res_word;
			end
		end
	end

	always_comb begin
		case (operand_sel)
			SEL_M_T: begin
				mp.a_word = m_mem[mp.a_index];
				mp.b_word = t_mem[mp.b_index];
			end
			SEL_C_C: begin
				mp.a_word = c_bar[mp.a_index];
				mp.b_word = c_bar[mp.b_index];
			end
			SEL_C_M: begin
				mp.a_word = c_bar[mp.a_index];
				mp.b_word = m_bar[mp.b_index];
			end
			SEL_ONE_C: begin
				mp.a_word = (mp.a_index == '0) ? word_t'(1) : '0; // the constant 1
				mp.b_word = c_bar[mp.b_index];
			end
			default: begin
				mp.a_word = '0;
				mp.b_word = '0;
			end
		endcase
	end

	assign mp.n_word = n_mem[mp.b_index];
	assign mp.nprime0 = nprime0;
	assign e_bit = e_mem[bit_index / WORD_WIDTH][bit_index % WORD_WIDTH];

	// result words leave one cycle after their counter value
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			res_valid <= 1'b0;
			res_out <= '0;
		end else if (stream_out) begin
			res_valid <= 1'b1;
			res_out <= c_bar[cnt];
		end else begin
			res_valid <= 1'b0;
			res_out <= '0;
		end
	end

endmodule

// File: source/mont_product.sv
/* word-serial CIOS Montgomery product a*b/R mod n on one registered 64x64 multiply-add
   a start pulse launches one product, done pulses on the cycle after the last result write */
`timescale 1ns/1ps

module mont_product #(
	parameter int WORD_COUNT = 64
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	output logic done,
	monpro_if.engine mp
);
	import mont_word_pkg::*;

	localparam int IDX_W = (WORD_COUNT > 1) ? $clog2(WORD_COUNT) : 1;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(WORD_COUNT - 1);

	typedef enum logic [2:0] {
		MUL_ACC,    // v += a[i] * b[j]
		MUL_TOP,    // fold the carry into v[s], v[s+1]
		QUOTIENT,   // q = v[0] * n'0 mod 2^64
		REDUCE,     // v = (v + q * n) >> 64
		REDUCE_TOP,
		CARRY_TOP,
		WRITE_BACK  // one result word per cycle
	} step_t;

	step_t step;
	logic busy;
	logic capture;            // second cycle of a multiply-add step
	logic [IDX_W-1:0] i;      // outer word of a
	logic [IDX_W-1:0] j;      // inner word of b and n
	word_t v [0:WORD_COUNT+1]; // accumulator
	word_t z;                 // running carry
	word_t q;
	word_t mac_x;
	word_t mac_y;
	word_t mac_z;
	word_t mac_c;
	dword_t mac_q;
	word_t mac_sum;
	word_t mac_carry;

	assign mac_sum = mac_q[WORD_WIDTH-1:0];
	assign mac_carry = mac_q[2*WORD_WIDTH-1:WORD_WIDTH];

	assign mp.a_index = i;
	assign mp.b_index = j;
	assign mp.res_we = busy && (step == WRITE_BACK);
	assign mp.res_index = j;
	assign mp.res_word = v[j];

	// operands of the multiply-add for the current step
	always_comb begin
		mac_x = '0;
		mac_y = '0;
		mac_z = '0;
		mac_c = '0;
		case (step)
			MUL_ACC: begin
				mac_x = mp.a_word;
				mac_y = mp.b_word;
				mac_z = v[j];
				mac_c = z;
			end
			MUL_TOP: begin
				mac_z = v[WORD_COUNT];
				mac_c = z;
			end
			QUOTIENT: begin
				mac_x = v[0];
				mac_y = mp.nprime0;
			end
			REDUCE: begin
				mac_x = q;
				mac_y = mp.n_word;
				mac_z = v[j];
				mac_c = (j == '0) ? '0 : z; // word 0 starts a fresh carry chain
			end
			REDUCE_TOP: begin
				mac_z = v[WORD_COUNT];
				mac_c = z;
			end
			CARRY_TOP: begin
				mac_z = v[WORD_COUNT+1];
				mac_c = z;
			end
			default: begin
			end
		endcase
	end

	// x*y + z + c never exceeds 2^128 - 1
	always_ff @(posedge clk) begin
		if (busy && !capture && step != WRITE_BACK) begin
			mac_q <= dword_t'(mac_x) * dword_t'(mac_y) + dword_t'(mac_z) + dword_t'(mac_c);
		end
		if (busy && capture && step == QUOTIENT) begin
			q <= mac_sum;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			step <= MUL_ACC;
			capture <= 1'b0;
			i <= '0;
			j <= '0;
			z <= '0;
			done <= 1'b0;
			for (int k = 0; k < WORD_COUNT + 2; k++) begin
				v[k] <= '0;
			end
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					step <= MUL_ACC;
					capture <= 1'b0;
					i <= '0;
					j <= '0;
					z <= '0;
				end
			end else if (step == WRITE_BACK) begin
				v[j] <= '0; // accumulator is left clear for the next product
				if (j == LAST_IDX) begin
					v[WORD_COUNT] <= '0;
					v[WORD_COUNT+1] <= '0;
					j <= '0;
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					j <= j + 1'b1;
				end
			end else if (!capture) begin
				capture <= 1'b1; // operands issued
			end else begin
				capture <= 1'b0;
				case (step)
					MUL_ACC: begin
						v[j] <= mac_sum;
						z <= mac_carry;
						if (j == LAST_IDX) begin
							j <= '0;
							step <= MUL_TOP;
						end else begin
							j <= j + 1'b1;
						end
					end
					MUL_TOP: begin
						v[WORD_COUNT] <= mac_sum;
						v[WORD_COUNT+1] <= mac_carry;
						step <= QUOTIENT;
					end
					QUOTIENT: step <= REDUCE;
					REDUCE: begin
						if (j != '0) begin
							v[j - 1'b1] <= mac_sum; // shift one word down
						end
						z <= mac_carry;
						if (j == LAST_IDX) begin
							j <= '0;
							step <= REDUCE_TOP;
						end else begin
							j <= j + 1'b1;
						end
					end
					REDUCE_TOP: begin
						v[WORD_COUNT-1] <= mac_sum;
						z <= mac_carry;
						step <= CARRY_TOP;
					end
					CARRY_TOP: begin
						v[WORD_COUNT] <= mac_sum;
						z <= '0;
						if (i == LAST_IDX) begin
							step <= WRITE_BACK;
						end else begin
							i <= i + 1'b1;
							step <= MUL_ACC;
						end
					end
					default: step <= MUL_ACC;
				endcase
			end
		end
	end

endmodule

// File: source/monpro_if.sv
/* operand read and result write port between the product engine and the operand memory
   reads are combinational from the indices, a result word is written on the res_we edge */
`timescale 1ns/1ps

interface monpro_if #(
	parameter int WORD_COUNT = 64
);
	import mont_word_pkg::*;

	localparam int IDX_W = (WORD_COUNT > 1) ? $clog2(WORD_COUNT) : 1;

	logic [IDX_W-1:0] a_index;
	logic [IDX_W-1:0] b_index;   // also addresses n
	logic res_we;
	logic [IDX_W-1:0] res_index;
	word_t res_word;
	word_t a_word;
	word_t b_word;
	word_t n_word;
	word_t nprime0;              // low word of n'

	modport engine (
		output a_index, b_index, res_we, res_index, res_word,
		input  a_word, b_word, n_word, nprime0
	);

	modport store (
		input  a_index, b_index, res_we, res_index, res_word,
		output a_word, b_word, n_word, nprime0
	);

endinterface

// File: source/modexp_ctrl_pkg.sv
/* control codes of the exponent sequencer and the operand pair selection
   shared by the sequencer, the operand memory and the top level */
package modexp_ctrl_pkg;

	typedef enum logic [3:0] {
		IDLE,
		LOAD_KEY,     // e, r, t, n and nprime0
		LOAD_MSG,     // m only
		WAIT_COMPUTE,
		TO_MONT,      // m_bar = monpro(m, t), c_bar = r
		FIND_TOP_BIT, // scan down to the leading one of e
		SQUARE,       // c_bar = monpro(c_bar, c_bar)
		MULTIPLY,     // c_bar = monpro(c_bar, m_bar)
		FROM_MONT,    // c_bar = monpro(1, c_bar)
		COMPLETE,
		OUTPUT,
		TERMINAL
	} exp_state_t;

	// which pair feeds the product engine and where its result lands
	typedef enum logic [1:0] {
		SEL_M_T,   // m x t into m_bar, r copied into c_bar
		SEL_C_C,   // c_bar x c_bar into c_bar
		SEL_C_M,   // c_bar x m_bar into c_bar
		SEL_ONE_C  // 1 x c_bar into c_bar
	} operand_sel_t;

endpackage

// File: source/mont_word_pkg.sv
/* arithmetic word width and word types shared by the Montgomery datapath and operand memory
   import where operand, modulus or product words are carried */
package mont_word_pkg;

	parameter int WORD_WIDTH = 64; // bits per arithmetic word

	// one operand, modulus or result word
	typedef logic [WORD_WIDTH-1:0] word_t;

	// product plus both addends of the multiply-add with the carry word in the high half
	typedef logic [2*WORD_WIDTH-1:0] dword_t;

endpackage
